/* common/mvu_pkg.sv */
// MVU shared definitions
// Sizes, vector types and the packed structs that pass between the job
// controller, the operand buffer and the bit-serial accumulator
`default_nettype none

package mvu_pkg;

    localparam int NLANES   = 8;                         // Vector elements per plane
    localparam int MEMDEPTH = 64;                        // Plane words per memory
    localparam int BADDR    = $clog2(MEMDEPTH);          // Plane address width
    localparam int MAXPREC  = 4;                         // Largest operand precision
    localparam int BPREC    = $clog2(MAXPREC + 1);       // Precision field, actual value
    localparam int BROWS    = 4;                         // Row count, 1 to 8
    localparam int BSHIFT   = $clog2(2 * MAXPREC - 1);   // Weight bit plus input bit
    localparam int BACC     = 16;                        // Accumulator and result width

    typedef logic        [NLANES-1:0] plane_t;           // One bit-plane word
    typedef logic        [BADDR-1:0]  addr_t;
    typedef logic        [BPREC-1:0]  prec_t;
    typedef logic        [BROWS-1:0]  rows_t;
    typedef logic        [BSHIFT-1:0] shift_t;
    typedef logic signed [BACC-1:0]   acc_t;

    // Job configuration, carried by the start strobe
    typedef struct packed {
        prec_t wprec;                                    // Weight precision
        prec_t iprec;                                    // Input precision
        addr_t wbase;                                    // Weight row 0 base address
        addr_t ibase;                                    // Input vector base address
        rows_t rows;                                     // Output rows
        logic  w_signed;
        logic  x_signed;
    } job_cfg_t;

    // Plane memory write port
    typedef struct packed {
        logic   en;
        addr_t  addr;
        plane_t word;
    } mem_wr_t;

    // Control that travels with each plane pair
    typedef struct packed {
        logic   last;                                    // Final pair of a row
        shift_t shift;                                   // Combined bit significance
        logic   negate;                                  // One operand on a signed MSB
    } pair_tag_t;

endpackage

`default_nettype wire

/* mvu_ctrl/mvu_job_ctrl.sv */
// MVU job controller
// Registers the job configuration on an accepted start and walks rows,
// weight bits and input bits, issuing one weight/data plane pair per cycle
// together with the tag the accumulator needs for that pair
`timescale 1ns/1ns
`default_nettype none

module mvu_job_ctrl (
    input  logic               intf,
    input  logic               rst_n,
    input  logic               start,
    input  mvu_pkg::job_cfg_t  cfg,
    output logic               busy,
    output logic               rd_valid,
    output mvu_pkg::addr_t     waddr,
    output mvu_pkg::addr_t     daddr,
    output mvu_pkg::pair_tag_t rd_tag
);
    import mvu_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_ISSUE
    } state_t;

    state_t    state;
    job_cfg_t  cfg_q;                                    // Configuration of the running job
    job_cfg_t  act_cfg;                                  // Config the next pair is built from
    rows_t     row_cnt;                                  // Counters of the pair just issued
    prec_t     wb_cnt;
    prec_t     ib_cnt;
    addr_t     row_base;                                 // Weight base of the current row
    rows_t     nxt_row;
    prec_t     nxt_wb;
    prec_t     nxt_ib;
    addr_t     nxt_base;
    pair_tag_t nxt_tag;
    logic      ib_last;
    logic      wb_last;
    logic      job_done;
    logic      issue_nxt;

    assign ib_last   = (ib_cnt == cfg_q.iprec - 1'b1);
    assign wb_last   = (wb_cnt == cfg_q.wprec - 1'b1);
    assign job_done  = ib_last && wb_last && (row_cnt == cfg_q.rows - 1'b1);
    assign issue_nxt = (state == ST_IDLE) ? start : !job_done;
    assign act_cfg   = (state == ST_IDLE) ? cfg : cfg_q; // First pair comes straight from cfg
    assign busy      = (state == ST_ISSUE);

    // Nested loops: input bit innermost, then weight bit, then row
    always_comb begin
        if (state == ST_IDLE) begin
            nxt_row  = '0;
            nxt_wb   = '0;
            nxt_ib   = '0;
            nxt_base = cfg.wbase;
        end else begin
            nxt_row  = row_cnt;
            nxt_wb   = wb_cnt;
            nxt_ib   = ib_cnt + 1'b1;
            nxt_base = row_base;
            if (ib_last) begin
                nxt_ib = '0;
                nxt_wb = wb_cnt + 1'b1;
                if (wb_last) begin
                    nxt_wb   = '0;
                    nxt_row  = row_cnt + 1'b1;
                    nxt_base = row_base + addr_t'(cfg_q.wprec); // Wraps modulo memory depth
                end
            end
        end
    end

    always_comb begin
        nxt_tag.last   = (nxt_wb == act_cfg.wprec - 1'b1) && (nxt_ib == act_cfg.iprec - 1'b1);
        nxt_tag.shift  = shift_t'(nxt_wb) + shift_t'(nxt_ib);
        // MSB of a signed operand carries negative weight
        nxt_tag.negate = (act_cfg.x_signed && (nxt_ib == act_cfg.iprec - 1'b1))
                       ^ (act_cfg.w_signed && (nxt_wb == act_cfg.wprec - 1'b1));
    end

    always_ff @(posedge intf or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            cfg_q    <= '0;
            row_cnt  <= '0;
            wb_cnt   <= '0;
            ib_cnt   <= '0;
            row_base <= '0;
            rd_valid <= 1'b0;
            waddr    <= '0;
            daddr    <= '0;
            rd_tag   <= '0;
        end else begin
            rd_valid <= issue_nxt;
            state    <= issue_nxt ? ST_ISSUE : ST_IDLE;
            if (state == ST_IDLE && start) begin
                cfg_q <= cfg;                            // Start while busy never gets here
            end
            if (issue_nxt) begin
                row_cnt  <= nxt_row;
                wb_cnt   <= nxt_wb;
                ib_cnt   <= nxt_ib;
                row_base <= nxt_base;
                waddr    <= nxt_base + addr_t'(nxt_wb);
                daddr    <= act_cfg.ibase + addr_t'(nxt_ib);
                rd_tag   <= nxt_tag;
            end
        end
    end

endmodule

`default_nettype wire

/* mvu_top.f */
common/mvu_pkg.sv
mvu_ctrl/mvu_job_ctrl.sv
verilog/mvu_operand_buf.sv
mvu_vvp/mvu_vvp_acc.sv
verilog/mvu_top.sv
tb/mvu_checker.sv
tb/tb_mvu_top.sv

/* mvu_vvp/mvu_vvp_acc.sv */
// MVU bit-serial vector product and row accumulator
// Each plane pair contributes popcount(w & x) scaled by its bit significance,
// negated when exactly one operand sits on a signed MSB. The last pair of a
// row closes the sum into result and the next pair starts a fresh sum.
`timescale 1ns/1ns
`default_nettype none

module mvu_vvp_acc (
    input  logic               intf,
    input  logic               rst_n,
    input  logic               plane_valid,
    input  mvu_pkg::plane_t    wplane,
    input  mvu_pkg::plane_t    dplane,
    input  mvu_pkg::pair_tag_t plane_tag,
    output mvu_pkg::acc_t      result,
    output logic               result_valid
);
    import mvu_pkg::*;

    plane_t masked;                                      // Lanes where both bits are set
    acc_t   ones;                                        // Popcount of masked
    acc_t   term;                                        // Shifted and signed contribution
    acc_t   acc_q;                                       // Running row sum
    acc_t   sum_nxt;

    assign masked = wplane & dplane;

    always_comb begin
        ones = '0;
        for (int j = 0; j < NLANES; j++) begin
            ones = ones + acc_t'(masked[j]);
        end
    end

    always_comb begin
        term = ones <<< plane_tag.shift;
        if (plane_tag.negate) begin
            term = -term;
        end
    end

    assign sum_nxt = acc_q + term;

    always_ff @(posedge intf or negedge rst_n) begin
        if (!rst_n) begin
            acc_q        <= '0;
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= plane_valid && plane_tag.last;
            if (plane_valid) begin
                if (plane_tag.last) begin
                    result <= sum_nxt;
                    acc_q  <= '0;                        // Next row starts clean, no gap cycle
                end else begin
                    acc_q <= sum_nxt;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the MVU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mvu_top.f --top-module tb_mvu_top -o sim_mvu
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_mvu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1

/* tb/mvu_checker.sv */
// MVU checker
// Mirrors the plane memories, captures accepted jobs, models busy and the
// row results from the data layout, and checks value and cycle of each strobe
`timescale 1ns/1ns
`default_nettype none

module mvu_checker (
    input  logic              intf,
    input  logic              rst_n,
    input  logic              start,
    input  mvu_pkg::job_cfg_t cfg,
    input  mvu_pkg::mem_wr_t  wmem_wr,
    input  mvu_pkg::mem_wr_t  dmem_wr,
    input  logic              busy,
    input  mvu_pkg::acc_t     result,
    input  logic              result_valid,
    input  logic              test_end,
    input  int                test_id,
    input  logic              report,
    output int                pending,
    output int                err_count
);
    import mvu_pkg::*;

    plane_t wm [MEMDEPTH];                               // Weight memory model
    plane_t dm [MEMDEPTH];                               // Data memory model
    acc_t   exp_q [$];                                   // Expected row results in order
    int     due_q [$];                                   // Cycle each one is due
    int     cyc = 0;
    int     busy_end = 0;                                // Last cycle busy is expected high
    int     checks = 0;
    int     test_base = 0;                               // Errors before the current test
    int     tests_run = 0;
    int     tests_failed = 0;
    acc_t   exp_val;
    int     due;

    initial pending = 0;
    initial err_count = 0;

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset";
            2:       return "unsigned jobs";
            3:       return "signed jobs";
            4:       return "multi-row jobs";
            5:       return "back-to-back jobs";
            6:       return "ignored start";
            default: return "unknown";
        endcase
    endfunction

    // Value of lane j of an operand stored as bit planes from base upward
    function automatic int element(input logic is_w, input int base, input int lane,
                                   input int prec, input logic sgn);
        int     v;
        plane_t word;
        v = 0;
        for (int b = 0; b < prec; b++) begin
            word = is_w ? wm[(base + b) % MEMDEPTH] : dm[(base + b) % MEMDEPTH];
            if (word[lane]) v = v + (1 << b);
        end
        if (sgn && v >= (1 << (prec - 1))) v = v - (1 << prec);
        return v;
    endfunction

    task automatic accept_job(input job_cfg_t c);
        int p;
        int sum;
        p        = int'(c.wprec) * int'(c.iprec);        // Pairs per row
        busy_end = cyc + int'(c.rows) * p;
        for (int k = 0; k < int'(c.rows); k++) begin
            sum = 0;
            for (int j = 0; j < NLANES; j++) begin
                sum += element(1'b1, int'(c.wbase) + k * int'(c.wprec), j,
                               int'(c.wprec), c.w_signed)
                     * element(1'b0, int'(c.ibase), j, int'(c.iprec), c.x_signed);
            end
            exp_q.push_back(acc_t'(sum));
            due_q.push_back(cyc + (k + 1) * p + 2);
        end
    endtask

    always @(posedge intf) begin
        cyc = cyc + 1;
        if (rst_n) begin
            checks++;
            if (busy !== (cyc <= busy_end)) begin
                $display("FAIL t=%0t busy: got %b expected %b", $time, busy, cyc <= busy_end);
                err_count++;
            end
            if (due_q.size() > 0 && due_q[0] < cyc) begin
                $display("Result due at cycle %0d never arrived", due_q[0]);
                exp_val = exp_q.pop_front();
                due     = due_q.pop_front();
                err_count++;
            end
            if (result_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected result strobe at cycle %0d", cyc);
                    err_count++;
                end else begin
                    exp_val = exp_q.pop_front();
                    due     = due_q.pop_front();
                    checks++;
                    if (due != cyc) begin
                        $display("Result strobe came at cycle %0d, due at cycle %0d", cyc, due);
                        err_count++;
                    end
                    if (result !== exp_val) begin
                        $display("FAIL t=%0t result: got %0d expected %0d",
                                 $time, result, exp_val);
                        err_count++;
                    end
                end
            end
        end
        // Writes land before any read of the next job
        if (wmem_wr.en) wm[wmem_wr.addr] = wmem_wr.word;
        if (dmem_wr.en) dm[dmem_wr.addr] = dmem_wr.word;
        if (rst_n && start && cyc > busy_end) accept_job(cfg);  // Idle in the model
        pending = due_q.size();
        if (test_end) begin
            tests_run++;
            if (err_count == test_base) begin
                $display("Test %0d (%s) passed", test_id, test_name(test_id));
            end else begin
                $display("Test %0d (%s) failed with %0d errors", test_id,
                         test_name(test_id), err_count - test_base);
                tests_failed++;
            end
            test_base = err_count;
        end
        if (report) begin
            if (due_q.size() != 0) begin
                $display("%0d expected results never arrived", due_q.size());
                err_count++;
            end
            $display("Checks %0d, errors %0d, tests %0d, tests failed %0d",
                     checks, err_count, tests_run, tests_failed);
        end
    end

endmodule

`default_nettype wire

/* tb/tb_mvu_top.sv */
// MVU testbench top
// Drives clock, reset, plane memory loads and randomized jobs into the MVU
// and sequences the six tests. The checker module does the comparing.
`timescale 1ns/1ns
`default_nettype none

module tb_mvu_top;
    import mvu_pkg::*;

    logic        intf;
    logic        rst_n;
    logic        start;
    job_cfg_t    cfg;
    mem_wr_t     wmem_wr;
    mem_wr_t     dmem_wr;
    logic        busy;
    acc_t        result;
    logic        result_valid;
    logic        test_end;                               // Closes the current test
    int          test_id;
    logic        report;                                 // Asks for the closing counts
    int          pending;                                // Results still expected
    int          err_count;
    logic [31:0] rng = 32'd60611;                        // Xorshift state
    int          cycles = 0;
    int          limit = 0;
    job_cfg_t    jobs [$];                               // Every job that gets accepted
    job_cfg_t    ignored_cfg;                            // Sent while busy, must be dropped
    addr_t       ext_wbase = 6'd40;                      // Most negative operand area
    addr_t       ext_ibase = 6'd20;

    mvu_top u_mvu_top (
        .intf         (intf),
        .rst_n        (rst_n),
        .start        (start),
        .cfg          (cfg),
        .wmem_wr      (wmem_wr),
        .dmem_wr      (dmem_wr),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid)
    );

    mvu_checker u_checker (
        .intf         (intf),
        .rst_n        (rst_n),
        .start        (start),
        .cfg          (cfg),
        .wmem_wr      (wmem_wr),
        .dmem_wr      (dmem_wr),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid),
        .test_end     (test_end),
        .test_id      (test_id),
        .report       (report),
        .pending      (pending),
        .err_count    (err_count)
    );

    initial begin
        intf = 1'b0;
        forever #50 intf = ~intf;
    end

    // Run limit, set from the planned jobs before reset is released
    always @(posedge intf) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic rand_bit();
        return (next_rand() % 2) == 1;
    endfunction

    function automatic job_cfg_t make_cfg(input int rows, input logic ws, input logic xs);
        job_cfg_t c;
        c.wprec    = prec_t'(1 + next_rand() % MAXPREC);
        c.iprec    = prec_t'(1 + next_rand() % MAXPREC);
        c.wbase    = addr_t'(next_rand() % MEMDEPTH);
        c.ibase    = addr_t'(next_rand() % MEMDEPTH);
        c.rows     = rows_t'(rows);
        c.w_signed = ws;
        c.x_signed = xs;
        return c;
    endfunction

    task automatic build_jobs();
        job_cfg_t c;
        for (int i = 0; i < 6; i++) begin
            jobs.push_back(make_cfg(1, 1'b0, 1'b0));     // Unsigned single rows
        end
        for (int i = 0; i < 4; i++) begin
            jobs.push_back(make_cfg(int'(next_rand() % 3) + 1, i[0], i[1]));
        end
        for (int i = 0; i < 4; i++) begin
            c       = make_cfg(2, i[0], i[1]);           // All operands at -8 when signed
            c.wprec = prec_t'(MAXPREC);
            c.iprec = prec_t'(MAXPREC);
            c.wbase = ext_wbase;
            c.ibase = ext_ibase;
            jobs.push_back(c);
        end
        for (int i = 0; i < 3; i++) begin
            jobs.push_back(make_cfg(int'(next_rand() % 7) + 2, rand_bit(), rand_bit()));
        end
        c       = make_cfg(4, rand_bit(), rand_bit());
        c.wprec = prec_t'(MAXPREC);
        c.wbase = addr_t'(60);                           // Rows at 60, 0, 4, 8
        jobs.push_back(c);
        for (int i = 0; i < 3; i++) begin
            jobs.push_back(make_cfg(int'(next_rand() % 8) + 1, rand_bit(), rand_bit()));
        end
        c       = make_cfg(3, rand_bit(), rand_bit());
        c.wprec = prec_t'(2);                            // Long enough to hit while busy
        jobs.push_back(c);
        ignored_cfg = make_cfg(5, rand_bit(), rand_bit());
    endtask

    task automatic step();
        @(posedge intf);
        #1;
    endtask

    task automatic start_job(input job_cfg_t c);
        cfg   = c;
        start = 1'b1;
        step();
        start = 1'b0;
    endtask

    task automatic wait_drain();
        while (busy) step();
        while (pending != 0) step();
    endtask

    task automatic run_job(input job_cfg_t c);
        start_job(c);
        wait_drain();
    endtask

    task automatic load_random();
        repeat (3) step();
        for (int a = 0; a < MEMDEPTH; a++) begin
            wmem_wr = '{en: 1'b1, addr: addr_t'(a), word: plane_t'(next_rand())};
            dmem_wr = '{en: 1'b1, addr: addr_t'(a), word: plane_t'(next_rand())};
            step();
        end
        wmem_wr.en = 1'b0;
        dmem_wr.en = 1'b0;
    endtask

    // Only the MSB plane set, so every lane is the most negative value
    task automatic load_extreme();
        repeat (3) step();
        for (int a = 0; a < 2 * MAXPREC; a++) begin
            wmem_wr = '{en: 1'b1, addr: ext_wbase + addr_t'(a), word: '0};
            dmem_wr = '{en: (a < MAXPREC), addr: ext_ibase + addr_t'(a), word: '0};
            if (a % MAXPREC == MAXPREC - 1) begin
                wmem_wr.word = '1;
                dmem_wr.word = '1;
            end
            step();
        end
        wmem_wr.en = 1'b0;
        dmem_wr.en = 1'b0;
    endtask

    task automatic end_test(input int id);
        test_id  = id;
        test_end = 1'b1;
        step();
        test_end = 1'b0;
    endtask

    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        cfg      = '0;
        wmem_wr  = '0;
        dmem_wr  = '0;
        test_end = 1'b0;
        test_id  = 0;
        report   = 1'b0;
        build_jobs();
        limit = 16 + 2 * (MEMDEPTH + 8) + 40;            // Reset, loads, idle gaps
        foreach (jobs[i]) begin
            limit += int'(jobs[i].rows) * int'(jobs[i].wprec) * int'(jobs[i].iprec) + 20;
        end
        repeat (16) @(posedge intf);
        #1;
        rst_n = 1'b1;
        repeat (10) step();                              // Quiet after reset
        end_test(1);
        load_random();
        for (int j = 0; j < 6; j++) run_job(jobs[j]);
        end_test(2);
        for (int j = 6; j < 10; j++) run_job(jobs[j]);
        load_extreme();
        for (int j = 10; j < 14; j++) run_job(jobs[j]);
        end_test(3);
        for (int j = 14; j < 18; j++) run_job(jobs[j]);
        end_test(4);
        start_job(jobs[18]);
        for (int j = 19; j < 21; j++) begin
            while (busy) step();                         // Start in the first idle cycle
            start_job(jobs[j]);
        end
        wait_drain();
        end_test(5);
        start_job(jobs[21]);
        repeat (2) step();
        cfg   = ignored_cfg;
        start = 1'b1;
        step();
        start = 1'b0;
        wait_drain();
        end_test(6);
        report = 1'b1;
        step();
        report = 1'b0;
        step();
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/mvu_operand_buf.sv */
// MVU operand buffer
// Weight and input bit-plane memories, written from outside and read one
// pair per cycle; valid and tag are delayed to leave with the read words
`timescale 1ns/1ns
`default_nettype none

module mvu_operand_buf (
    input  logic               intf,
    input  logic               rst_n,
    input  mvu_pkg::mem_wr_t   wmem_wr,
    input  mvu_pkg::mem_wr_t   dmem_wr,
    input  logic               rd_valid,
    input  mvu_pkg::addr_t     waddr,
    input  mvu_pkg::addr_t     daddr,
    input  mvu_pkg::pair_tag_t rd_tag,
    output logic               plane_valid,
    output mvu_pkg::plane_t    wplane,
    output mvu_pkg::plane_t    dplane,
    output mvu_pkg::pair_tag_t plane_tag
);
    import mvu_pkg::*;

    plane_t wmem [MEMDEPTH];                             // Weight bit planes
    plane_t dmem [MEMDEPTH];                             // Input data bit planes

    // Weight memory, write port and registered read
    always_ff @(posedge intf) begin
        if (wmem_wr.en) begin
            wmem[wmem_wr.addr] <= wmem_wr.word;
        end
        if (rd_valid) begin
            wplane <= wmem[waddr];                       // Same-address write returns old word
        end
    end

    // Data memory, same arrangement
    always_ff @(posedge intf) begin
        if (dmem_wr.en) begin
            dmem[dmem_wr.addr] <= dmem_wr.word;
        end
        if (rd_valid) begin
            dplane <= dmem[daddr];
        end
    end

    // Control follows the one-cycle read latency
    always_ff @(posedge intf or negedge rst_n) begin
        if (!rst_n) begin
            plane_valid <= 1'b0;
            plane_tag   <= '0;
        end else begin
            plane_valid <= rd_valid;
            plane_tag   <= rd_tag;
        end
    end

endmodule

`default_nettype wire

/* verilog/mvu_top.sv */
// MVU top level
// Single bit-serial matrix-vector unit: job controller issues plane pairs,
// the operand buffer reads them and the accumulator produces row results
`timescale 1ns/1ns
`default_nettype none

module mvu_top (
    input  logic              intf,
    input  logic              rst_n,
    input  logic              start,
    input  mvu_pkg::job_cfg_t cfg,
    input  mvu_pkg::mem_wr_t  wmem_wr,
    input  mvu_pkg::mem_wr_t  dmem_wr,
    output logic              busy,
    output mvu_pkg::acc_t     result,
    output logic              result_valid
);
    import mvu_pkg::*;

    logic      rd_valid;                                 // Pair issued this cycle
    addr_t     waddr;
    addr_t     daddr;
    pair_tag_t rd_tag;
    logic      plane_valid;                              // Pair read words ready
    plane_t    wplane;
    plane_t    dplane;
    pair_tag_t plane_tag;

    mvu_job_ctrl u_job_ctrl (
        .intf        (intf),
        .rst_n       (rst_n),
        .start       (start),
        .cfg         (cfg),
        .busy        (busy),
        .rd_valid    (rd_valid),
        .waddr       (waddr),
        .daddr       (daddr),
        .rd_tag      (rd_tag)
    );

    mvu_operand_buf u_operand_buf (
        .intf        (intf),
        .rst_n       (rst_n),
        .wmem_wr     (wmem_wr),
        .dmem_wr     (dmem_wr),
        .rd_valid    (rd_valid),
        .waddr       (waddr),
        .daddr       (daddr),
        .rd_tag      (rd_tag),
        .plane_valid (plane_valid),
        .wplane      (wplane),
        .dplane      (dplane),
        .plane_tag   (plane_tag)
    );

    mvu_vvp_acc u_vvp_acc (
        .intf         (intf),
        .rst_n        (rst_n),
        .plane_valid  (plane_valid),
        .wplane       (wplane),
        .dplane       (dplane),
        .plane_tag    (plane_tag),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire
